/* Bender.yml */
package:
  name: clk_rst_controller

sources:
  - clk_rst_pkg.sv
  - clk_rst_axil_regs.sv
  - clk_channel_divider.sv
  - rst_channel_sequencer.sv
  - clk_rst_controller.sv
  - target: test
    files:
      - tb_clk_rst_controller.sv

/* clk_channel_divider.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_channel_divider #(
  parameter int reset_division = 2
) (
  input  logic              mst_clk_after_pll,
  input  logic              mst_rst_n_d2_mst_clk,
  input  clk_rst_pkg::div_t div_load_i,
  input  logic              load_i,
  output logic              clk_o,
  output logic              edge_o
);

  clk_rst_pkg::div_t pending_q;
  clk_rst_pkg::div_t active_q;
  clk_rst_pkg::div_t cnt_q;
  clk_rst_pkg::div_t next_pending;
  clk_rst_pkg::div_t next_active;
  clk_rst_pkg::div_t cnt_next;
  logic              clk_q;
  logic              bypass_div;
  logic              wrap;

  // Divisions of 0 and 1 pass the master clock
  assign bypass_div = active_q < clk_rst_pkg::div_t'(2);

  // Last cycle of a period
  assign wrap = bypass_div || (cnt_q == active_q - clk_rst_pkg::div_t'(1));

  assign next_pending = load_i ? div_load_i : pending_q;
  // A new divisor only starts at a period boundary
  assign next_active  = wrap ? next_pending : active_q;
  assign cnt_next     = wrap ? '0 : cnt_q + clk_rst_pkg::div_t'(1);

  always_ff @(posedge mst_clk_after_pll or negedge mst_rst_n_d2_mst_clk) begin
    if (!mst_rst_n_d2_mst_clk) begin
      pending_q <= clk_rst_pkg::div_t'(reset_division);
      active_q  <= clk_rst_pkg::div_t'(reset_division);
      cnt_q     <= '0;
      clk_q     <= (reset_division >= 2);
    end else begin
      pending_q <= next_pending;
      active_q  <= next_active;
      cnt_q     <= cnt_next;
      // High for the first half of the period, rounded down
      clk_q     <= cnt_next < (next_active >> 1);
    end
  end

  assign edge_o = wrap;
  assign clk_o  = bypass_div ? mst_clk_after_pll : clk_q;

  edge_before_rise: assert property (@(posedge mst_clk_after_pll)
    disable iff (!mst_rst_n_d2_mst_clk) (!bypass_div && edge_o) |-> !clk_q);

endmodule

`default_nettype wire

/* clk_rst_axil_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_rst_axil_regs (
  input  logic                           mst_clk_after_pll,
  input  logic                           mst_rst_n_d2_mst_clk,
  input  clk_rst_pkg::axil_req_t         axil_req_i,
  output clk_rst_pkg::axil_rsp_t         axil_rsp_o,
  output clk_rst_pkg::div_load_t         div_load_o,
  output logic [clk_rst_pkg::num_clocks-1:0] local_rst_pulse_o
);

  clk_rst_pkg::div_t [clk_rst_pkg::num_clocks-1:0] div_q;
  logic [clk_rst_pkg::num_clocks-1:0] load_q;
  logic [clk_rst_pkg::num_clocks-1:0] rst_pulse_q;

  logic       b_valid_q;
  logic [1:0] b_resp_q;
  logic       r_valid_q;
  logic [1:0] r_resp_q;
  logic [clk_rst_pkg::axil_data_width-1:0] r_data_q;

  logic       wr_hs;
  logic       rd_hs;
  logic [1:0] wr_resp;
  logic       wr_high_bits;

  //////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////
  assign wr_hs = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
  assign wr_high_bits = |axil_req_i.w_data[clk_rst_pkg::axil_data_width-1:clk_rst_pkg::num_clocks];

  always_comb begin
    case (axil_req_i.aw_addr)
      clk_rst_pkg::addr_division: wr_resp = clk_rst_pkg::resp_okay;
      clk_rst_pkg::addr_valid,
      clk_rst_pkg::addr_reset: begin
        wr_resp = wr_high_bits ? clk_rst_pkg::resp_slverr : clk_rst_pkg::resp_okay;
      end
      default: wr_resp = clk_rst_pkg::resp_slverr;
    endcase
  end

  always_ff @(posedge mst_clk_after_pll or negedge mst_rst_n_d2_mst_clk) begin
    if (!mst_rst_n_d2_mst_clk) begin
      for (int i = 0; i < clk_rst_pkg::num_clocks; i++) begin
        div_q[i] <= clk_rst_pkg::div_t'(clk_rst_pkg::default_division[i]);
      end
      load_q      <= '0;
      rst_pulse_q <= '0;
      b_valid_q   <= 1'b0;
      b_resp_q    <= clk_rst_pkg::resp_okay;
    end else begin
      // Write-one bits only last a single cycle
      load_q      <= '0;
      rst_pulse_q <= '0;
      if (wr_hs) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_resp;
        if (axil_req_i.aw_addr == clk_rst_pkg::addr_division) begin
          for (int i = 0; i < clk_rst_pkg::num_clocks; i++) begin
            if (axil_req_i.w_strb[i]) begin
              div_q[i] <= axil_req_i.w_data[i*8 +: clk_rst_pkg::div_width];
            end
          end
        end
        if (axil_req_i.aw_addr == clk_rst_pkg::addr_valid) begin
          load_q <= axil_req_i.w_data[clk_rst_pkg::num_clocks-1:0];
        end
        if (axil_req_i.aw_addr == clk_rst_pkg::addr_reset) begin
          rst_pulse_q <= axil_req_i.w_data[clk_rst_pkg::num_clocks-1:0];
        end
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////
  assign rd_hs = axil_req_i.ar_valid & ~r_valid_q;

  always_ff @(posedge mst_clk_after_pll or negedge mst_rst_n_d2_mst_clk) begin
    if (!mst_rst_n_d2_mst_clk) begin
      r_valid_q <= 1'b0;
      r_resp_q  <= clk_rst_pkg::resp_okay;
    end else if (rd_hs) begin
      r_valid_q <= 1'b1;
      r_resp_q  <= clk_rst_pkg::resp_slverr;
      if (axil_req_i.ar_addr == clk_rst_pkg::addr_division ||
          axil_req_i.ar_addr == clk_rst_pkg::addr_valid ||
          axil_req_i.ar_addr == clk_rst_pkg::addr_reset) begin
        r_resp_q <= clk_rst_pkg::resp_okay;
      end
    end else if (axil_req_i.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // Only the division register has readable content
  always_ff @(posedge mst_clk_after_pll) begin
    if (rd_hs) begin
      r_data_q <= (axil_req_i.ar_addr == clk_rst_pkg::addr_division) ? div_q : '0;
    end
  end

  assign axil_rsp_o.aw_ready = wr_hs;
  assign axil_rsp_o.w_ready  = wr_hs;
  assign axil_rsp_o.b_resp   = b_resp_q;
  assign axil_rsp_o.b_valid  = b_valid_q;
  assign axil_rsp_o.ar_ready = ~r_valid_q;
  assign axil_rsp_o.r_data   = r_data_q;
  assign axil_rsp_o.r_resp   = r_resp_q;
  assign axil_rsp_o.r_valid  = r_valid_q;

  assign div_load_o.division = div_q;
  assign div_load_o.load     = load_q;
  assign local_rst_pulse_o   = rst_pulse_q;

  b_valid_held: assert property (@(posedge mst_clk_after_pll) disable iff (!mst_rst_n_d2_mst_clk)
    b_valid_q && !axil_req_i.b_ready |=> b_valid_q);

  load_single_cycle: assert property (@(posedge mst_clk_after_pll)
    disable iff (!mst_rst_n_d2_mst_clk) |load_q |=> !(|load_q));

endmodule

`default_nettype wire

/* clk_rst_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_rst_controller (
  input  logic                               mst_clk_i,
  input  logic                               mst_rst_ni,
  input  logic                               bypass_i,
  input  clk_rst_pkg::axil_req_t             axil_req_i,
  output clk_rst_pkg::axil_rsp_t             axil_rsp_o,
  output logic                               clk_obs_o,
  output logic [clk_rst_pkg::num_clocks-1:0] clk_o,
  output logic [clk_rst_pkg::num_clocks-1:0] rst_no
);

  logic mst_clk_after_pll;
  logic mst_rst_n_d1_mst_clk;
  logic mst_rst_n_d2_mst_clk;

  clk_rst_pkg::div_load_t             div_load;
  logic [clk_rst_pkg::num_clocks-1:0] local_rst_pulse;
  logic [clk_rst_pkg::num_clocks-1:0] div_clk;
  logic [clk_rst_pkg::num_clocks-1:0] div_edge;
  logic                               obs_clk;

  assign mst_clk_after_pll = mst_clk_i;

  //////////////////////////////////////////////////
  // Master reset synchronizer
  //////////////////////////////////////////////////
  always_ff @(posedge mst_clk_after_pll or negedge mst_rst_ni) begin
    if (!mst_rst_ni) begin
      mst_rst_n_d1_mst_clk <= 1'b0;
      mst_rst_n_d2_mst_clk <= 1'b0;
    end else begin
      mst_rst_n_d1_mst_clk <= 1'b1;
      mst_rst_n_d2_mst_clk <= mst_rst_n_d1_mst_clk;
    end
  end

  clk_rst_axil_regs i_regs (
    .mst_clk_after_pll   (mst_clk_after_pll),
    .mst_rst_n_d2_mst_clk(mst_rst_n_d2_mst_clk),
    .axil_req_i          (axil_req_i),
    .axil_rsp_o          (axil_rsp_o),
    .div_load_o          (div_load),
    .local_rst_pulse_o   (local_rst_pulse)
  );

  //////////////////////////////////////////////////
  // Channels
  //////////////////////////////////////////////////
  for (genvar i = 0; i < clk_rst_pkg::num_clocks; i++) begin : gen_channel
    clk_channel_divider #(
      .reset_division(clk_rst_pkg::default_division[i])
    ) i_divider (
      .mst_clk_after_pll   (mst_clk_after_pll),
      .mst_rst_n_d2_mst_clk(mst_rst_n_d2_mst_clk),
      .div_load_i          (div_load.division[i]),
      .load_i              (div_load.load[i]),
      .clk_o               (div_clk[i]),
      .edge_o              (div_edge[i])
    );

    rst_channel_sequencer #(
      .hold_edges(clk_rst_pkg::reset_delays[i])
    ) i_sequencer (
      .mst_clk_after_pll   (mst_clk_after_pll),
      .mst_rst_n_d2_mst_clk(mst_rst_n_d2_mst_clk),
      .local_rst_i         (local_rst_pulse[i]),
      .edge_i              (div_edge[i]),
      .rst_no              (rst_no[i])
    );
  end

  // Observation clock, never reprogrammed
  clk_channel_divider #(
    .reset_division(clk_rst_pkg::obs_division)
  ) i_obs_divider (
    .mst_clk_after_pll   (mst_clk_after_pll),
    .mst_rst_n_d2_mst_clk(mst_rst_n_d2_mst_clk),
    .div_load_i          (clk_rst_pkg::div_t'(clk_rst_pkg::obs_division)),
    .load_i              (1'b0),
    .clk_o               (obs_clk),
    .edge_o              ()
  );

  assign clk_o     = bypass_i ? {clk_rst_pkg::num_clocks{mst_clk_after_pll}} : div_clk;
  assign clk_obs_o = bypass_i ? mst_clk_after_pll : obs_clk;

endmodule

`default_nettype wire

/* clk_rst_pkg.sv */
`default_nettype none

package clk_rst_pkg;

  //////////////////////////////////////////////////
  // Channel configuration
  //////////////////////////////////////////////////
  localparam int num_clocks = 4;
  localparam int div_width  = 8;

  typedef logic [div_width-1:0] div_t;

  // Division each channel comes out of reset with
  localparam int default_division[num_clocks] = '{2, 4, 6, 8};
  // Divided-clock edges each channel stays in reset
  localparam int reset_delays[num_clocks] = '{2, 3, 4, 5};

  // Fixed divisor of the observation clock
  localparam int obs_division = 128;

  //////////////////////////////////////////////////
  // AXI4-Lite register map
  //////////////////////////////////////////////////
  localparam int axil_addr_width = 8;
  localparam int axil_data_width = 32;

  localparam logic [axil_addr_width-1:0] addr_division = 8'h00;
  localparam logic [axil_addr_width-1:0] addr_valid    = 8'h04;
  localparam logic [axil_addr_width-1:0] addr_reset    = 8'h08;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef struct packed {
    logic [axil_addr_width-1:0]   aw_addr;
    logic                         aw_valid;
    logic [axil_data_width-1:0]   w_data;
    logic [axil_data_width/8-1:0] w_strb;
    logic                         w_valid;
    logic                         b_ready;
    logic [axil_addr_width-1:0]   ar_addr;
    logic                         ar_valid;
    logic                         r_ready;
  } axil_req_t;

  typedef struct packed {
    logic                       aw_ready;
    logic                       w_ready;
    logic [1:0]                 b_resp;
    logic                       b_valid;
    logic                       ar_ready;
    logic [axil_data_width-1:0] r_data;
    logic [1:0]                 r_resp;
    logic                       r_valid;
  } axil_rsp_t;

  // Division values with a per-channel load strobe
  typedef struct packed {
    div_t [num_clocks-1:0]   division;
    logic [num_clocks-1:0]   load;
  } div_load_t;

endpackage

`default_nettype wire

/* clk_rst_testdata.txt */
# name kind chan val exp (hex). write: chan={strb,addr} val=data exp=resp
# read: chan=addr val=resp exp=data; period/obs/reset: exp=cycles/edges; bypass: val=on
dflt_p0   period 0   0        2
dflt_p1   period 1   0        4
dflt_p2   period 2   0        6
dflt_p3   period 3   0        8
rd_dflt   read   0   0        08060402
wr_div    write  f00 0a030c05 0
wr_strb   write  200 ffff07ff 0
rd_div    read   0   0        0a030705
wr_valid  write  f04 5        0
new_p0    period 0   0        5
keep_p1   period 1   0        4
new_p2    period 2   0        3
keep_p3   period 3   0        8
rst_ch1   reset  1   0        3
rst_ch3   reset  3   0        5
wr_bad    write  f10 1        2
wr_vhi    write  f04 10       2
rd_bad    read   20  2        0
rd_valid  read   4   0        0
rd_reset  read   8   0        0
obs_per   obs    0   0        80
byp_on    bypass 0   1        1
byp_off   bypass 0   0        0
after_byp period 0   0        5

/* rst_channel_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module rst_channel_sequencer #(
  parameter int hold_edges = 2
) (
  input  logic mst_clk_after_pll,
  input  logic mst_rst_n_d2_mst_clk,
  input  logic local_rst_i,
  input  logic edge_i,
  output logic rst_no
);

  clk_rst_pkg::div_t edge_cnt_q;
  logic              rst_released_q;
  logic              last_edge;

  // Release lands on the same master edge as the divided clock rising
  assign last_edge = edge_i &&
                     (edge_cnt_q == clk_rst_pkg::div_t'(hold_edges - 1));

  //////////////////////////////////////////////////
  // Hold counter
  //////////////////////////////////////////////////
  always_ff @(posedge mst_clk_after_pll or negedge mst_rst_n_d2_mst_clk) begin
    if (!mst_rst_n_d2_mst_clk) begin
      edge_cnt_q     <= '0;
      rst_released_q <= 1'b0;
    end else if (local_rst_i) begin
      // Restart even when already counting
      edge_cnt_q     <= '0;
      rst_released_q <= 1'b0;
    end else if (!rst_released_q && edge_i) begin
      if (last_edge) begin
        edge_cnt_q     <= '0;
        rst_released_q <= 1'b1;
      end else begin
        edge_cnt_q <= edge_cnt_q + clk_rst_pkg::div_t'(1);
      end
    end
  end

  assign rst_no = rst_released_q;

  rst_after_pulse: assert property (@(posedge mst_clk_after_pll)
    disable iff (!mst_rst_n_d2_mst_clk) local_rst_i |=> !rst_no);

endmodule

`default_nettype wire

/* src.f */
clk_rst_pkg.sv
clk_rst_axil_regs.sv
clk_channel_divider.sv
rst_channel_sequencer.sv
clk_rst_controller.sv
tb_clk_rst_controller.sv

/* tb_clk_rst_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_rst_controller;

  localparam int max_tests = 64;
  localparam int num_mon   = clk_rst_pkg::num_clocks + 1;

  logic                               mst_clk;
  logic                               mst_rst_n;
  logic                               bypass;
  clk_rst_pkg::axil_req_t             req;
  clk_rst_pkg::axil_rsp_t             rsp;
  logic                               clk_obs;
  logic [clk_rst_pkg::num_clocks-1:0] clk_div;
  logic [clk_rst_pkg::num_clocks-1:0] rst_n_ch;
  logic [num_mon-1:0]                 mon_clk;

  string       name_a[max_tests];
  string       kind_a[max_tests];
  logic [31:0] chan_a[max_tests];
  logic [31:0] val_a[max_tests];
  logic [31:0] exp_a[max_tests];
  int          num_tests;
  int          errors;
  int          cycles;
  int          cycle_limit;
  int          rises[num_mon];
  time         prev_rise[num_mon];
  time         last_rise[num_mon];

  clk_rst_controller DUT (
    .mst_clk_i (mst_clk),
    .mst_rst_ni(mst_rst_n),
    .bypass_i  (bypass),
    .axil_req_i(req),
    .axil_rsp_o(rsp),
    .clk_obs_o (clk_obs),
    .clk_o     (clk_div),
    .rst_no    (rst_n_ch)
  );

  always #5 mst_clk = ~mst_clk;

  always @(posedge mst_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Run stopped at cycle %0d before all tests ended, %0d errors", cycles, errors);
      $display("Errors found");
      $finish;
    end
  end

  // Index num_clocks is the observation clock
  assign mon_clk = {clk_obs, clk_div};

  for (genvar g = 0; g < num_mon; g++) begin : gen_edge_mon
    always @(posedge mon_clk[g]) begin
      rises[g]     = rises[g] + 1;
      prev_rise[g] = last_rise[g];
      last_rise[g] = $time;
    end
  end

  //////////////////////////////////////////////////
  // Checks and AXI4-Lite driver
  //////////////////////////////////////////////////
  task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] got);
    assert (got === expv) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, expv, got);
      errors++;
    end
  endtask

  // sel holds the byte strobes above the address
  task automatic axi_access(input logic is_read, input logic [11:0] sel,
                            input logic [31:0] data, input int hold,
                            output logic [1:0] resp, output logic [31:0] rdata);
    int guard;
    guard = 0;
    @(posedge mst_clk);
    req.ar_addr  <= sel[7:0];
    req.ar_valid <= is_read;
    req.aw_addr  <= sel[7:0];
    req.w_strb   <= sel[11:8];
    req.w_data   <= data;
    req.aw_valid <= !is_read;
    req.w_valid  <= !is_read;
    req.b_ready  <= (hold == 0);
    req.r_ready  <= (hold == 0);
    @(negedge mst_clk);
    while (!(is_read ? rsp.ar_ready : rsp.aw_ready) && guard < 40) begin
      @(negedge mst_clk);
      guard++;
    end
    assert (guard < 40) else begin
      $display("Address handshake never happened for address %0h", sel[7:0]);
      errors++;
    end
    @(posedge mst_clk);
    req.aw_valid <= 1'b0;
    req.w_valid  <= 1'b0;
    req.ar_valid <= 1'b0;
    guard = 0;
    @(negedge mst_clk);
    while (!(is_read ? rsp.r_valid : rsp.b_valid) && guard < 40) begin
      @(negedge mst_clk);
      guard++;
    end
    assert (guard < 40) else begin
      $display("No response arrived for address %0h", sel[7:0]);
      errors++;
    end
    resp  = is_read ? rsp.r_resp : rsp.b_resp;
    rdata = rsp.r_data;
    // Response must stay up while ready is held off
    for (int k = 0; k < hold; k++) begin
      @(negedge mst_clk);
      assert (is_read ? rsp.r_valid : rsp.b_valid) else begin
        $display("Response for address %0h dropped before it was accepted", sel[7:0]);
        errors++;
      end
    end
    if (hold > 0) begin
      @(posedge mst_clk);
      req.b_ready <= 1'b1;
      req.r_ready <= 1'b1;
    end
    @(posedge mst_clk);
    req.b_ready <= 1'b0;
    req.r_ready <= 1'b0;
  endtask

  task automatic measure_period(input int idx, output int period);
    int start;
    int guard;
    // Start between master edges so no rise is in flight
    @(negedge mst_clk);
    start = rises[idx];
    guard = 0;
    while (rises[idx] < start + 2 && guard < 600) begin
      @(negedge mst_clk);
      guard++;
    end
    assert (guard < 600) else begin
      $display("Clock %0d stopped making rising edges", idx);
      errors++;
    end
    period = (last_rise[idx] - prev_rise[idx]) / 10;
  endtask

  task automatic check_reset(input string name, input int ch, input logic [31:0] expv);
    logic [1:0]                         resp;
    logic [31:0]                        rdata;
    logic [clk_rst_pkg::num_clocks-1:0] mask;
    int                                 start;
    int                                 guard;
    logic                               others_high;
    mask     = '0;
    mask[ch] = 1'b1;
    guard       = 0;
    others_high = 1'b1;
    axi_access(1'b0, {4'hf, clk_rst_pkg::addr_reset}, 32'h1 << ch, 0, resp, rdata);
    @(negedge mst_clk);
    assert (!rst_n_ch[ch]) else begin
      $display("Reset of channel %0d did not go low after the reset write", ch);
      errors++;
    end
    start = rises[ch];
    while (!rst_n_ch[ch] && guard < 4096) begin
      if (!(&(rst_n_ch | mask))) begin
        others_high = 1'b0;
      end
      @(negedge mst_clk);
      guard++;
    end
    assert (guard < 4096) else begin
      $display("Reset of channel %0d was never released", ch);
      errors++;
    end
    compare(name, expv, rises[ch] - start);
    assert (others_high) else begin
      $display("Another channel went into reset during test %s", name);
      errors++;
    end
  endtask

  task automatic check_bypass(input string name, input logic on, input logic [31:0] expv);
    int period;
    if (on) begin
      @(posedge mst_clk);
      bypass <= 1'b1;
      @(negedge mst_clk);
      for (int m = 0; m < num_mon; m++) begin
        measure_period(m, period);
        compare(name, expv, period);
      end
    end else begin
      repeat (1 + $urandom % 8) @(posedge mst_clk);
      bypass <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////
  task automatic load_tests();
    int    fd;
    int    code;
    string tok;
    string line;
    fd = $fopen("clk_rst_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open clk_rst_testdata.txt");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(line, fd);
        end else if (num_tests < max_tests) begin
          name_a[num_tests] = tok;
          code = $fscanf(fd, "%s %h %h %h", kind_a[num_tests], chan_a[num_tests],
                         val_a[num_tests], exp_a[num_tests]);
          if (code != 4) begin
            $display("Line for test %s is missing fields", tok);
            errors++;
          end
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic int test_length(input int t);
    if (kind_a[t] == "period") begin
      return 3 * exp_a[t];
    end else if (kind_a[t] == "obs") begin
      return 2 * exp_a[t];
    end else if (kind_a[t] == "reset") begin
      return 40 + exp_a[t] * 256;
    end
    return 40;
  endfunction

  task automatic run_test(input int t);
    logic [1:0]  resp;
    logic [31:0] rdata;
    int          period;
    int          ch;
    ch = int'(chan_a[t]);
    if (kind_a[t] == "write") begin
      axi_access(1'b0, chan_a[t][11:0], val_a[t], 1 + $urandom % 3, resp, rdata);
      compare(name_a[t], exp_a[t], resp);
    end else if (kind_a[t] == "read") begin
      axi_access(1'b1, chan_a[t][11:0], 32'h0, 1 + $urandom % 3, resp, rdata);
      compare(name_a[t], val_a[t], resp);
      compare(name_a[t], exp_a[t], rdata);
    end else if (kind_a[t] == "period" || kind_a[t] == "obs") begin
      measure_period(kind_a[t] == "obs" ? clk_rst_pkg::num_clocks : ch, period);
      compare(name_a[t], exp_a[t], period);
    end else if (kind_a[t] == "reset") begin
      check_reset(name_a[t], ch, exp_a[t]);
    end else if (kind_a[t] == "bypass") begin
      check_bypass(name_a[t], val_a[t][0], exp_a[t]);
    end else begin
      $display("Test %s has an unknown kind %s", name_a[t], kind_a[t]);
      errors++;
    end
  endtask

  initial begin
    int                                 rnd;
    int                                 guard;
    int                                 base[clk_rst_pkg::num_clocks];
    logic [clk_rst_pkg::num_clocks-1:0] seen;
    rnd       = $urandom(32'he9b0);
    mst_clk   = 1'b0;
    mst_rst_n = 1'b0;
    bypass    = 1'b0;
    req       = '0;
    load_tests();
    cycle_limit = 300;
    for (int t = 0; t < num_tests; t++) begin
      cycle_limit += test_length(t) + 8;
    end
    repeat (8) @(posedge mst_clk);
    mst_rst_n <= 1'b1;
    // Divided clocks stay frozen until the synchronized reset lifts
    for (int c = 0; c < clk_rst_pkg::num_clocks; c++) begin
      base[c] = rises[c];
    end
    seen  = '0;
    guard = 0;
    while (seen != '1 && guard < 200) begin
      @(negedge mst_clk);
      guard++;
      for (int c = 0; c < clk_rst_pkg::num_clocks; c++) begin
        if (rst_n_ch[c] && !seen[c]) begin
          seen[c] = 1'b1;
          compare("pwr_rst", clk_rst_pkg::reset_delays[c], rises[c] - base[c]);
        end
      end
    end
    assert (seen == '1) else begin
      $display("Channel resets were not all released after power-up");
      errors++;
    end
    for (int t = 0; t < num_tests; t++) begin
      repeat ($urandom % 4) @(posedge mst_clk);
      run_test(t);
    end
    $display("Ran %0d tests, %0d errors", num_tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
